/* vlog.f */
axil_pkg.sv
mem_if.sv
fifo_small.sv
axil_fifo_client.sv
wait_timer.sv
scratch_ctrl.sv
scratch_mem.sv
axil_scratch_top.sv
tb_axil_scratch.sv

/* Bender.yml */
package:
  name: axil_scratch

sources:
  - axil_pkg.sv
  - mem_if.sv
  - fifo_small.sv
  - axil_fifo_client.sv
  - wait_timer.sv
  - scratch_ctrl.sv
  - scratch_mem.sv
  - axil_scratch_top.sv
  - target: test
    files:
      - tb_axil_scratch.sv

/* tb_axil_scratch.sv */
module tb_axil_scratch;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 2;
  localparam int FIFO_DEPTH  = 4;
  localparam int MEM_WORDS   = 64;
  localparam int WAIT_CYCLES = 3;
  localparam int BURST_LEN   = 6;

  // Row kinds
  localparam logic [1:0] K_WR = 2'd0;
  localparam logic [1:0] K_RD = 2'd1;
  localparam logic [1:0] K_RW = 2'd2;
  localparam logic [1:0] K_RB = 2'd3;

  typedef struct packed {
    logic [1:0]           kind;
    axil_pkg::axil_addr_t addr;
    axil_pkg::axil_data_t data;
    axil_pkg::axil_strb_t strb;
    logic                 stall;
  } row_t;

  typedef struct packed {
    logic                 w;
    axil_pkg::axil_data_t data;
  } rsp_t;

  localparam int N_ROWS = 17;
  localparam row_t ROWS [N_ROWS] = '{
    '{K_WR, 12'h040, 32'hdead_beef, 4'hf, 1'b0},
    '{K_RD, 12'h040, 32'h0, 4'h0, 1'b0},
    '{K_WR, 12'h044, 32'h1122_3344, 4'h5, 1'b0},
    '{K_WR, 12'h044, 32'haabb_ccdd, 4'h8, 1'b0},
    '{K_RD, 12'h044, 32'h0, 4'h0, 1'b0},
    // Unaligned, then the same word seen through the wrap
    '{K_RD, 12'h0a5, 32'h0, 4'h0, 1'b0},
    '{K_RD, 12'h1a4, 32'h0, 4'h0, 1'b0},
    '{K_WR, 12'h3fc, 32'h0bad_f00d, 4'h3, 1'b0},
    '{K_RD, 12'h0fc, 32'h0, 4'h0, 1'b0},
    '{K_RW, 12'h080, 32'hcafe_0001, 4'hf, 1'b0},
    '{K_RD, 12'h080, 32'h0, 4'h0, 1'b0},
    '{K_RW, 12'h084, 32'h5a5a_a5a5, 4'h6, 1'b1},
    '{K_WR, 12'h088, 32'h0f0f_7777, 4'hc, 1'b1},
    '{K_RD, 12'h088, 32'h0, 4'h0, 1'b1},
    '{K_RB, 12'h020, 32'h0, 4'h0, 1'b0},
    '{K_RB, 12'h030, 32'h0, 4'h0, 1'b1},
    // Burst that runs past the last word
    '{K_RB, 12'h7f0, 32'h0, 4'h0, 1'b1}
  };

  // Fill writes count as rows here
  localparam int TIMEOUT = (N_ROWS + MEM_WORDS) * (WAIT_CYCLES + 10) * 16 * CLK_PERIOD;

  logic                 clk_i;
  logic                 rst_i;
  axil_pkg::axil_addr_t awaddr_i;
  axil_pkg::axil_prot_t awprot_i;
  logic                 awvalid_i;
  logic                 awready_o;
  axil_pkg::axil_data_t wdata_i;
  axil_pkg::axil_strb_t wstrb_i;
  logic                 wvalid_i;
  logic                 wready_o;
  axil_pkg::axil_resp_e bresp_o;
  logic                 bvalid_o;
  logic                 bready_i;
  axil_pkg::axil_addr_t araddr_i;
  axil_pkg::axil_prot_t arprot_i;
  logic                 arvalid_i;
  logic                 arready_o;
  axil_pkg::axil_data_t rdata_o;
  axil_pkg::axil_resp_e rresp_o;
  logic                 rvalid_o;
  logic                 rready_i;

  axil_pkg::axil_data_t shadow [MEM_WORDS];
  rsp_t                 exp_q [$];
  logic [31:0]          rnd;
  logic                 stall_en;
  logic                 r_held;
  logic                 b_held;
  axil_pkg::axil_data_t r_held_data;

  axil_scratch_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .MEM_WORDS(MEM_WORDS),
    .WAIT_CYCLES(WAIT_CYCLES)
  ) u_axil_scratch_top (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte address to scratchpad word, high bits dropped
  function automatic int word_idx(input axil_pkg::axil_addr_t addr);
    return int'(addr >> 2) % MEM_WORDS;
  endfunction

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_data(input string name, input axil_pkg::axil_data_t got,
                            input axil_pkg::axil_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input axil_pkg::axil_resp_e got,
                            input axil_pkg::axil_resp_e exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_order(input logic got_w, input logic exp_w);
    if (got_w !== exp_w) begin
      stop_run($sformatf("Fail response kind (1 is B): got %h, expected %h", got_w, exp_w));
    end
  endtask

  task automatic take_rsp(input logic is_w, input axil_pkg::axil_data_t data,
                          input axil_pkg::axil_resp_e resp);
    rsp_t e;
    if (exp_q.size() == 0) begin
      stop_run("A response arrived with no transaction outstanding");
    end
    e = exp_q.pop_front();
    check_order(is_w, e.w);
    if (!is_w) begin
      check_data("rdata_o", data, e.data);
    end
    check_resp(is_w ? "bresp_o" : "rresp_o", resp, axil_pkg::OKAY);
  endtask

  task automatic expect_read(input axil_pkg::axil_addr_t addr);
    exp_q.push_back('{1'b0, shadow[word_idx(addr)]});
  endtask

  // Lane merge into the shadow word
  task automatic expect_write(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
                              input axil_pkg::axil_strb_t strb);
    int idx;
    idx = word_idx(addr);
    for (int i = 0; i < axil_pkg::AXIL_STRB_W; i++) begin
      if (strb[i]) shadow[idx][8*i +: 8] = data[8*i +: 8];
    end
    exp_q.push_back('{1'b1, 32'h0});
  endtask

  task automatic send_ar(input axil_pkg::axil_addr_t addr);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!arready_o);
    @(posedge clk_i);
    #DRIVE_DLY;
    arvalid_i = 1'b0;
  endtask

  task automatic send_aw_w(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
                           input axil_pkg::axil_strb_t strb);
    logic aw_take;
    logic w_take;
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    wvalid_i  = 1'b1;
    while (awvalid_i || wvalid_i) begin
      @(negedge clk_i);
      aw_take = awready_o;
      w_take  = wready_o;
      @(posedge clk_i);
      #DRIVE_DLY;
      if (aw_take) awvalid_i = 1'b0;
      if (w_take) wvalid_i = 1'b0;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #DRIVE_DLY;
    end
  endtask

  // Random ready drops on stalled rows
  always @(posedge clk_i) begin
    logic stall_now;
    stall_now = stall_en;
    #DRIVE_DLY;
    if (stall_now) begin
      rnd      = xorshift(rnd);
      rready_i = rnd[3];
      bready_i = rnd[11];
    end else begin
      rready_i = 1'b1;
      bready_i = 1'b1;
    end
  end

  // Response monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (r_held && !rvalid_o) stop_run("rvalid dropped before its handshake");
      if (r_held) check_data("rdata_o", rdata_o, r_held_data);
      if (b_held && !bvalid_o) stop_run("bvalid dropped before its handshake");
      if (rvalid_o && rready_i) take_rsp(1'b0, rdata_o, rresp_o);
      if (bvalid_o && bready_i) take_rsp(1'b1, 32'h0, bresp_o);
      r_held      = rvalid_o && !rready_i;
      r_held_data = rdata_o;
      b_held      = bvalid_o && !bready_i;
    end
  end

  initial begin
    #TIMEOUT;
    stop_run("Timeout: the run hung waiting for a response or a ready");
  end

  initial begin
    axil_pkg::axil_addr_t a;
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    awaddr_i  = '0;
    awprot_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b1;
    araddr_i  = '0;
    arprot_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    rnd       = 32'hdb3f_7846;
    stall_en  = 1'b0;
    r_held    = 1'b0;
    b_held    = 1'b0;
    repeat (3) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;

    // Fill every word so that all later reads are defined
    for (int w = 0; w < MEM_WORDS; w++) begin
      a = axil_pkg::axil_addr_t'(4 * w);
      expect_write(a, {a, ~a, 8'hc3}, '1);
      send_aw_w(a, {a, ~a, 8'hc3}, '1);
    end
    wait_drain();

    foreach (ROWS[i]) begin
      stall_en = ROWS[i].stall;
      case (ROWS[i].kind)
        K_WR: begin
          expect_write(ROWS[i].addr, ROWS[i].data, ROWS[i].strb);
          send_aw_w(ROWS[i].addr, ROWS[i].data, ROWS[i].strb);
        end
        K_RD: begin
          expect_read(ROWS[i].addr);
          send_ar(ROWS[i].addr);
        end
        K_RW: begin
          // Read wins, so it sees the old word
          expect_read(ROWS[i].addr);
          expect_write(ROWS[i].addr, ROWS[i].data, ROWS[i].strb);
          fork
            send_ar(ROWS[i].addr);
            send_aw_w(ROWS[i].addr, ROWS[i].data, ROWS[i].strb);
          join
        end
        default: begin
          for (int j = 0; j < BURST_LEN; j++) begin
            a = ROWS[i].addr + axil_pkg::axil_addr_t'(4 * j);
            expect_read(a);
            send_ar(a);
          end
        end
      endcase
      wait_drain();
    end

    stall_en = 1'b0;
    repeat (10) @(posedge clk_i);
    if (exp_q.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_run("Responses still outstanding at the end of the run");
    end
  end

endmodule

/* axil_scratch_top.sv */
module axil_scratch_top #(
  parameter int FIFO_DEPTH  = 4,
  parameter int MEM_WORDS   = 64,
  parameter int WAIT_CYCLES = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  axil_pkg::axil_addr_t   awaddr_i,
  input  axil_pkg::axil_prot_t   awprot_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,

  input  axil_pkg::axil_data_t   wdata_i,
  input  axil_pkg::axil_strb_t   wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,

  output axil_pkg::axil_resp_e   bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,

  input  axil_pkg::axil_addr_t   araddr_i,
  input  axil_pkg::axil_prot_t   arprot_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,

  output axil_pkg::axil_data_t   rdata_o,
  output axil_pkg::axil_resp_e   rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i
);

  logic tmr_start;
  logic tmr_done;

  mem_req_if                            mem_req ();
  mem_port_if #(.MEM_WORDS(MEM_WORDS))  mem_port ();

  axil_fifo_client #(.FIFO_DEPTH(FIFO_DEPTH)) u_client (
    .clk_i, .rst_i,
    .awaddr_i, .awprot_i, .awvalid_i, .awready_o,
    .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arprot_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .mem(mem_req.client)
  );

  scratch_ctrl #(.MEM_WORDS(MEM_WORDS)) u_ctrl (
    .clk_i, .rst_i,
    .req(mem_req.target),
    .mem(mem_port.ctrl),
    .tmr_start_o(tmr_start),
    .tmr_done_i(tmr_done)
  );

  // Models the late response of the scratchpad
  wait_timer #(.WAIT_CYCLES(WAIT_CYCLES)) u_timer (
    .clk_i, .rst_i,
    .start_i(tmr_start),
    .busy_o(),
    .done_o(tmr_done)
  );

  scratch_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk_i,
    .mem(mem_port.array)
  );

endmodule

/* scratch_mem.sv */
module scratch_mem #(
  parameter int MEM_WORDS = 64
) (
  input  logic        clk_i,
  mem_port_if.array   mem
);

  localparam int LANES = axil_pkg::AXIL_STRB_W;

  axil_pkg::axil_data_t mem_q [MEM_WORDS];

  // Write under the lane mask, otherwise register a read
  always_ff @(posedge clk_i) begin
    if (mem.en) begin
      if (mem.we) begin
        for (int i = 0; i < LANES; i++) begin
          if (mem.wmask[i]) begin
            mem_q[mem.word_addr][8*i +: 8] <= mem.wdata[8*i +: 8];
          end
        end
      end else begin
        mem.rdata <= mem_q[mem.word_addr];
      end
    end
  end

endmodule

/* scratch_ctrl.sv */
module scratch_ctrl #(
  parameter int MEM_WORDS = 64
) (
  input  logic        clk_i,
  input  logic        rst_i,

  mem_req_if.target   req,
  mem_port_if.ctrl    mem,

  output logic        tmr_start_o,
  input  logic        tmr_done_i
);

  localparam int IDX_W    = $clog2(MEM_WORDS);
  localparam int WORD_LSB = $clog2(axil_pkg::AXIL_STRB_W);

  axil_pkg::scratch_state_e state_q;
  axil_pkg::scratch_state_e state_d;
  logic                     accept;
  logic                     rd_pend_q;
  axil_pkg::axil_data_t     rsp_data_q;

  assign req.req_ready = (state_q == axil_pkg::IDLE);
  assign accept        = req.req_v & req.req_ready;

  // Memory port is driven only in the accept cycle
  assign mem.en        = accept;
  assign mem.we        = req.req_w;
  assign mem.word_addr = req.req_addr[WORD_LSB +: IDX_W];
  assign mem.wdata     = req.req_data;
  assign mem.wmask     = req.req_wmask;

  assign tmr_start_o = accept;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      axil_pkg::IDLE: if (req.req_v) state_d = axil_pkg::WAIT;
      axil_pkg::WAIT: if (tmr_done_i) state_d = axil_pkg::RESP;
      axil_pkg::RESP: if (req.rsp_ready) state_d = axil_pkg::IDLE;
      default:        state_d = axil_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= axil_pkg::IDLE;
      rd_pend_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      rd_pend_q <= accept & ~req.req_w;
    end
  end

  // Array output is valid the cycle after a read enable
  always_ff @(posedge clk_i) begin
    if (rd_pend_q) begin
      rsp_data_q <= mem.rdata;
    end
  end

  assign req.rsp_v    = (state_q == axil_pkg::RESP);
  assign req.rsp_data = rsp_data_q;

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    req.rsp_v && !req.rsp_ready |=> $stable(req.rsp_data))
    else $error("scratch_ctrl: response data changed while stalled");

  // At most one request inside the memory side
  a_one_in_flight: assert property (@(posedge clk_i) disable iff (rst_i)
    accept |=> !req.req_ready until_with (req.rsp_v && req.rsp_ready))
    else $error("scratch_ctrl: new request accepted before response");

endmodule

/* wait_timer.sv */
module wait_timer #(
  parameter int WAIT_CYCLES = 3
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  output logic busy_o,
  output logic done_o
);

  localparam int CNT_W = $clog2(WAIT_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(WAIT_CYCLES);

  logic [CNT_W-1:0] cnt_q;

  // Down-counter, parked at zero when idle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_LOAD;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = (cnt_q != '0);

  // Last counted cycle, WAIT_CYCLES after start
  assign done_o = (cnt_q == CNT_W'(1));

  a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> !busy_o)
    else $error("wait_timer: start while busy");

endmodule

/* axil_fifo_client.sv */
module axil_fifo_client #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Write address
  input  axil_pkg::axil_addr_t   awaddr_i,
  input  axil_pkg::axil_prot_t   awprot_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,

  // Write data
  input  axil_pkg::axil_data_t   wdata_i,
  input  axil_pkg::axil_strb_t   wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,

  // Write response
  output axil_pkg::axil_resp_e   bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,

  // Read address
  input  axil_pkg::axil_addr_t   araddr_i,
  input  axil_pkg::axil_prot_t   arprot_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,

  // Read data
  output axil_pkg::axil_data_t   rdata_o,
  output axil_pkg::axil_resp_e   rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,

  mem_req_if.client              mem
);

  localparam int W_W = axil_pkg::AXIL_STRB_W + axil_pkg::AXIL_DATA_W;
  localparam axil_pkg::axil_addr_t LANE_MASK = axil_pkg::axil_addr_t'(axil_pkg::AXIL_STRB_W - 1);

  axil_pkg::axil_addr_t ar_addr;
  axil_pkg::axil_addr_t aw_addr;
  axil_pkg::axil_data_t w_data;
  axil_pkg::axil_strb_t w_strb;
  logic [W_W-1:0]       w_head;
  logic                 ar_v;
  logic                 aw_v;
  logic                 w_v;
  logic                 ar_yumi;
  logic                 aw_yumi;
  logic                 ret_ready;
  logic                 ret_w;
  logic                 ret_v;
  logic                 ret_yumi;
  logic                 issue;
  logic                 sel_rd;
  logic                 wr_hold_q;

  // awprot_i and arprot_i are accepted and ignored
  assign bresp_o = axil_pkg::OKAY;
  assign rresp_o = axil_pkg::OKAY;

  fifo_small #(.WIDTH(axil_pkg::AXIL_ADDR_W), .DEPTH(FIFO_DEPTH)) u_ar_fifo (
    .clk_i, .rst_i,
    .data_i(araddr_i), .v_i(arvalid_i), .ready_o(arready_o),
    .data_o(ar_addr), .v_o(ar_v), .yumi_i(ar_yumi)
  );

  fifo_small #(.WIDTH(axil_pkg::AXIL_ADDR_W), .DEPTH(FIFO_DEPTH)) u_aw_fifo (
    .clk_i, .rst_i,
    .data_i(awaddr_i), .v_i(awvalid_i), .ready_o(awready_o),
    .data_o(aw_addr), .v_o(aw_v), .yumi_i(aw_yumi)
  );

  fifo_small #(.WIDTH(W_W), .DEPTH(FIFO_DEPTH)) u_w_fifo (
    .clk_i, .rst_i,
    .data_i({wstrb_i, wdata_i}), .v_i(wvalid_i), .ready_o(wready_o),
    .data_o(w_head), .v_o(w_v), .yumi_i(aw_yumi)
  );

  assign {w_strb, w_data} = w_head;

  // One bit per issued request, set for writes
  fifo_small #(.WIDTH(1), .DEPTH(FIFO_DEPTH)) u_ret_fifo (
    .clk_i, .rst_i,
    .data_i(mem.req_w), .v_i(issue), .ready_o(ret_ready),
    .data_o(ret_w), .v_o(ret_v), .yumi_i(ret_yumi)
  );

  // Reads win, unless a write was already offered and is still waiting
  assign sel_rd = ar_v & ~wr_hold_q;

  assign mem.req_v     = ret_ready & (sel_rd | (aw_v & w_v));
  assign mem.req_w     = ~sel_rd;
  assign mem.req_addr  = sel_rd ? (ar_addr & ~LANE_MASK) : aw_addr;
  assign mem.req_data  = w_data;
  assign mem.req_wmask = w_strb;

  assign issue   = mem.req_v & mem.req_ready;
  assign ar_yumi = issue & sel_rd;
  assign aw_yumi = issue & ~sel_rd;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_hold_q <= 1'b0;
    end else begin
      wr_hold_q <= mem.req_v & ~mem.req_ready & ~sel_rd;
    end
  end

  // Steer each response by the oldest return entry
  assign rdata_o       = mem.rsp_data;
  assign rvalid_o      = mem.rsp_v & ret_v & ~ret_w;
  assign bvalid_o      = mem.rsp_v & ret_v & ret_w;
  assign mem.rsp_ready = ret_v & (ret_w ? bready_i : rready_i);
  assign ret_yumi      = mem.rsp_v & mem.rsp_ready;

  a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem.req_v && !mem.req_ready |=>
      mem.req_v && $stable(mem.req_w) && $stable(mem.req_addr))
    else $error("axil_fifo_client: request changed before accept");

endmodule

/* fifo_small.sv */
module fifo_small #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,

  input  logic [WIDTH-1:0] data_i,
  input  logic             v_i,
  output logic             ready_o,

  output logic [WIDTH-1:0] data_o,
  output logic             v_o,
  input  logic             yumi_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  logic [WIDTH-1:0] buf_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Full and empty both come from the occupancy count
  assign ready_o = (count_q != CNT_FULL);
  assign v_o     = (count_q != '0);

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  // Head is read straight out of the storage registers
  assign data_o = buf_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Consumer must only take a valid head
  a_no_yumi_empty: assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> v_o)
    else $error("fifo_small: yumi while empty");

endmodule

/* mem_if.sv */
// Request and response between the AXI client and the scratch controller
interface mem_req_if;

  logic                 req_v;
  logic                 req_w;
  axil_pkg::axil_addr_t req_addr;
  axil_pkg::axil_data_t req_data;
  axil_pkg::axil_strb_t req_wmask;
  logic                 req_ready;

  logic                 rsp_v;
  axil_pkg::axil_data_t rsp_data;
  logic                 rsp_ready;

  modport client (
    output req_v, req_w, req_addr, req_data, req_wmask, rsp_ready,
    input  req_ready, rsp_v, rsp_data
  );

  modport target (
    input  req_v, req_w, req_addr, req_data, req_wmask, rsp_ready,
    output req_ready, rsp_v, rsp_data
  );

endinterface

// Single port between the controller and the word array
interface mem_port_if #(
  parameter int MEM_WORDS = 64
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic                 en;
  logic                 we;
  logic [IDX_W-1:0]     word_addr;
  axil_pkg::axil_data_t wdata;
  axil_pkg::axil_strb_t wmask;
  axil_pkg::axil_data_t rdata;

  modport ctrl  (output en, we, word_addr, wdata, wmask, input rdata);
  modport array (input en, we, word_addr, wdata, wmask, output rdata);

endinterface

/* axil_pkg.sv */
package axil_pkg;

  // Bus widths
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_ADDR_W = 12;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // One bus word, one byte address, one lane mask
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;

  // Protection bits, carried on AW and AR only
  typedef logic [2:0] axil_prot_t;

  // Response codes on B and R
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Scratchpad controller states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    WAIT = 2'b01,
    RESP = 2'b10
  } scratch_state_e;

endpackage
